// ==== flist.f ====
hw/corr_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/capture_ctrl.sv
hw/pulse_counter.sv
hw/correlator.sv
hw/packet_tx.sv
hw/corr_top.sv
test/tb_corr_top.sv

// ==== hw/capture_ctrl.sv ====
// Command decoder and window timer
`timescale 1ns/1ps

module capture_ctrl #(
	parameter int WINDOW_UNIT = corr_pkg::WINDOW_UNIT
) (
	input logic intclk,
	input logic reset,
	input corr_pkg::byte_t cmd,
	input logic cmd_valid,
	output corr_pkg::lines_t invert,
	output logic window_active,
	output logic window_done,
	output corr_pkg::byte_t frame_id
);
	import corr_pkg::*;

	// Longest window is 2**6 steps
	localparam int CNT_W = $clog2((1 << $bits(arg_t)) * WINDOW_UNIT);

	opcode_e op;
	arg_t arg;
	arg_t win_arg;
	arg_t cur_arg;
	logic start_cmd;
	logic stop_cmd;
	logic [CNT_W-1:0] cyc_cnt;
	logic [CNT_W-1:0] last_cnt;
	byte_t next_id;

	assign op = opcode_e'(cmd[7:6]);
	assign arg = cmd[5:0];
	assign start_cmd = cmd_valid && (op == OP_RUN) && arg[0];
	assign stop_cmd = cmd_valid && (op == OP_RUN) && !arg[0];

	assign last_cnt = CNT_W'((int'(cur_arg) + 1) * WINDOW_UNIT - 1);
	assign window_done = window_active && (cyc_cnt == last_cnt);

	always_ff @(posedge intclk) begin
		if (reset) begin
			invert <= '0;
			win_arg <= '0;
		end else if (cmd_valid) begin
			case (op)
				OP_WINDOW: win_arg <= arg;
				OP_INVERT: invert <= arg[NUM_INPUTS-1:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			window_active <= 1'b0;
			cyc_cnt <= '0;
			cur_arg <= '0;
		end else if (stop_cmd) begin
			// Partial window is thrown away
			window_active <= 1'b0;
			cyc_cnt <= '0;
		end else if (start_cmd && !window_active) begin
			window_active <= 1'b1;
			cyc_cnt <= '0;
			cur_arg <= win_arg;
		end else if (window_done) begin
			// Next window starts at once, with the newest length
			cyc_cnt <= '0;
			cur_arg <= win_arg;
		end else if (window_active) begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	// frame_id holds the id of the last finished window
	always_ff @(posedge intclk) begin
		if (reset) begin
			next_id <= '0;
			frame_id <= '0;
		end else if (window_done) begin
			frame_id <= next_id;
			next_id <= next_id + 1'b1;
		end
	end

endmodule

// ==== hw/corr_pkg.sv ====
// Correlator shared definitions
package corr_pkg;

	localparam int NUM_INPUTS = 4;
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int WINDOW_UNIT = 64;

	typedef logic [15:0] count_t;
	typedef logic [7:0] byte_t;
	typedef logic [NUM_INPUTS-1:0] lines_t;
	// Command argument, low six bits of a command byte
	typedef logic [5:0] arg_t;

	// Index 0 is the leftmost word, so it goes out first
	typedef count_t [0:NUM_INPUTS-1] line_counts_t;
	typedef count_t [0:NUM_BASELINES-1] base_counts_t;

	// Baseline order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	localparam int BASE_FIRST [NUM_BASELINES] = '{0, 0, 0, 1, 1, 2};
	localparam int BASE_SECOND [NUM_BASELINES] = '{1, 2, 3, 2, 3, 3};

	localparam byte_t SYNC_BYTE = 8'hA5;

	typedef enum logic [1:0] {
		OP_NONE = 2'b00,
		OP_WINDOW = 2'b01,
		OP_INVERT = 2'b10,
		OP_RUN = 2'b11
	} opcode_e;

	typedef struct packed {
		byte_t frame_id;
		line_counts_t counts;
		line_counts_t autos;
		base_counts_t cross_sums;
	} corr_result_t;

	// Sync byte plus the result struct
	localparam int PKT_BYTES = 1 + $bits(corr_result_t) / 8;

endpackage

// ==== hw/corr_top.sv ====
// Photon pulse correlator top level
`timescale 1ns/1ps

module corr_top #(
	parameter int BAUD_DIV = 8
) (
	input logic intclk,
	input logic reset,
	input corr_pkg::lines_t line_in,
	input logic rx,
	output logic tx,
	output logic integrating
);
	import corr_pkg::*;

	byte_t cmd;
	logic cmd_valid;
	lines_t invert;
	logic window_active;
	logic window_done;
	byte_t frame_id;
	lines_t sample;
	lines_t prev_sample;
	line_counts_t counts;
	line_counts_t autos;
	base_counts_t cross_sums;
	logic result_valid;
	corr_result_t result;
	byte_t tx_data;
	logic tx_valid;
	logic tx_ready;

	assign integrating = window_active;

	assign result.frame_id = frame_id;
	assign result.counts = counts;
	assign result.autos = autos;
	assign result.cross_sums = cross_sums;

	uart_rx #(.BAUD_DIV(BAUD_DIV)) uart_rx_inst (
		.intclk(intclk), .reset(reset), .rx(rx), .cmd(cmd), .cmd_valid(cmd_valid)
	);

	capture_ctrl #(.WINDOW_UNIT(WINDOW_UNIT)) capture_ctrl_inst (
		.intclk(intclk), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid),
		.invert(invert), .window_active(window_active), .window_done(window_done),
		.frame_id(frame_id)
	);

	pulse_counter pulse_counter_inst (
		.intclk(intclk), .reset(reset), .line_in(line_in), .invert(invert),
		.window_active(window_active), .window_done(window_done), .sample(sample),
		.prev_sample(prev_sample), .counts(counts), .result_valid(result_valid)
	);

	correlator correlator_inst (
		.intclk(intclk), .reset(reset), .sample(sample), .prev_sample(prev_sample),
		.window_active(window_active), .window_done(window_done),
		.autos(autos), .cross_sums(cross_sums)
	);

	packet_tx packet_tx_inst (
		.intclk(intclk), .reset(reset), .result(result), .result_valid(result_valid),
		.tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
	);

	uart_tx #(.BAUD_DIV(BAUD_DIV)) uart_tx_inst (
		.intclk(intclk), .reset(reset), .data(tx_data), .valid(tx_valid),
		.ready(tx_ready), .tx(tx)
	);

endmodule

// ==== hw/correlator.sv ====
// Lag-1 auto and zero-lag cross correlator
`timescale 1ns/1ps

module correlator (
	input logic intclk,
	input logic reset,
	input corr_pkg::lines_t sample,
	input corr_pkg::lines_t prev_sample,
	input logic window_active,
	input logic window_done,
	output corr_pkg::line_counts_t autos,
	output corr_pkg::base_counts_t cross_sums
);
	import corr_pkg::*;

	// Auto products first, then baselines
	localparam int NUM_PROD = NUM_INPUTS + NUM_BASELINES;

	logic [NUM_PROD-1:0] prod;
	count_t acc [NUM_PROD];

	always_comb begin
		for (int i = 0; i < NUM_INPUTS; i++)
			prod[i] = sample[i] & prev_sample[i];
		for (int b = 0; b < NUM_BASELINES; b++)
			prod[NUM_INPUTS + b] = sample[BASE_FIRST[b]] & sample[BASE_SECOND[b]];
	end

	always_ff @(posedge intclk) begin
		for (int k = 0; k < NUM_PROD; k++) begin
			if (reset || !window_active || window_done)
				acc[k] <= '0;
			else
				acc[k] <= acc[k] + count_t'(prod[k]);
		end
	end

	// Loaded on the same edge as the ones counts
	always_ff @(posedge intclk) begin
		if (window_done) begin
			for (int i = 0; i < NUM_INPUTS; i++)
				autos[i] <= acc[i] + count_t'(prod[i]);
			for (int b = 0; b < NUM_BASELINES; b++)
				cross_sums[b] <= acc[NUM_INPUTS + b] + count_t'(prod[NUM_INPUTS + b]);
		end
	end

endmodule

// ==== hw/packet_tx.sv ====
// Result packet serializer
`timescale 1ns/1ps

module packet_tx (
	input logic intclk,
	input logic reset,
	input corr_pkg::corr_result_t result,
	input logic result_valid,
	output corr_pkg::byte_t tx_data,
	output logic tx_valid,
	input logic tx_ready
);
	import corr_pkg::*;

	localparam int IDX_W = $clog2(PKT_BYTES);

	corr_result_t held;
	logic [PKT_BYTES*8-1:0] pkt;
	logic [IDX_W-1:0] byte_idx;
	logic busy;
	logic last_byte;

	// Struct order already matches the wire order, MSB first
	assign pkt = {SYNC_BYTE, held};
	assign tx_data = pkt[(PKT_BYTES - 1 - byte_idx) * 8 +: 8];
	assign tx_valid = busy;
	assign last_byte = (byte_idx == IDX_W'(PKT_BYTES - 1));

	always_ff @(posedge intclk) begin
		if (!busy && result_valid)
			held <= result;
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			busy <= 1'b0;
			byte_idx <= '0;
		end else if (!busy) begin
			// Results arriving while busy are dropped
			byte_idx <= '0;
			busy <= result_valid;
		end else if (tx_ready) begin
			byte_idx <= byte_idx + 1'b1;
			if (last_byte)
				busy <= 1'b0;
		end
	end

endmodule

// ==== hw/pulse_counter.sv ====
// Line sampler and ones counter
`timescale 1ns/1ps

module pulse_counter (
	input logic intclk,
	input logic reset,
	input corr_pkg::lines_t line_in,
	input corr_pkg::lines_t invert,
	input logic window_active,
	input logic window_done,
	output corr_pkg::lines_t sample,
	output corr_pkg::lines_t prev_sample,
	output corr_pkg::line_counts_t counts,
	output logic result_valid
);
	import corr_pkg::*;

	count_t acc [NUM_INPUTS];

	// Runs on every edge, also outside windows
	always_ff @(posedge intclk) begin
		sample <= line_in ^ invert;
		prev_sample <= sample;
	end

	always_ff @(posedge intclk) begin
		for (int i = 0; i < NUM_INPUTS; i++) begin
			if (reset || !window_active || window_done)
				acc[i] <= '0;
			else
				acc[i] <= acc[i] + count_t'(sample[i]);
		end
	end

	// Final edge of the window still counts
	always_ff @(posedge intclk) begin
		if (window_done) begin
			for (int i = 0; i < NUM_INPUTS; i++)
				counts[i] <= acc[i] + count_t'(sample[i]);
		end
	end

	always_ff @(posedge intclk) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= window_done;
	end

endmodule

// ==== hw/uart_rx.sv ====
// UART command receiver
`timescale 1ns/1ps

module uart_rx #(
	parameter int BAUD_DIV = 8
) (
	input logic intclk,
	input logic reset,
	input logic rx,
	output corr_pkg::byte_t cmd,
	output logic cmd_valid
);
	import corr_pkg::*;

	localparam int CNT_W = $clog2(BAUD_DIV + 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e state;
	logic [1:0] rx_sync;
	logic rx_s;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0] bit_idx;
	logic bit_tick;
	logic half_tick;

	assign rx_s = rx_sync[1];
	assign bit_tick = (baud_cnt == CNT_W'(BAUD_DIV - 1));
	assign half_tick = (baud_cnt == CNT_W'(BAUD_DIV / 2 - 1));

	always_ff @(posedge intclk) begin
		if (reset) begin
			rx_sync <= 2'b11;
			state <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			cmd_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			cmd_valid <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx_s)
						state <= RX_START;
				end
				RX_START: begin
					// Middle of the start bit, glitches go back to idle
					if (half_tick) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx_s ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_tick) begin
						baud_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_tick) begin
						state <= RX_IDLE;
						cmd_valid <= rx_s;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge intclk) begin
		if (state == RX_DATA && bit_tick)
			cmd <= {rx_s, cmd[7:1]};
	end

endmodule

// ==== hw/uart_tx.sv ====
// UART byte transmitter
`timescale 1ns/1ps

module uart_tx #(
	parameter int BAUD_DIV = 8
) (
	input logic intclk,
	input logic reset,
	input corr_pkg::byte_t data,
	input logic valid,
	output logic ready,
	output logic tx
);
	import corr_pkg::*;

	localparam int CNT_W = $clog2(BAUD_DIV + 1);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

	tx_state_e state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0] bit_idx;
	logic bit_end;
	byte_t shreg;

	assign ready = (state == TX_IDLE);
	assign bit_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));
	assign tx = (state == TX_START) ? 1'b0 : (state == TX_DATA) ? shreg[0] : 1'b1;

	always_ff @(posedge intclk) begin
		if (reset) begin
			state <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
		end else begin
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					baud_cnt <= '0;
					bit_idx <= '0;
					if (valid)
						state <= TX_START;
				end
				TX_START: if (bit_end) state <= TX_DATA;
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= TX_STOP;
					end
				end
				TX_STOP: if (bit_end) state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge intclk) begin
		if (ready && valid)
			shreg <= data;
		else if (state == TX_DATA && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

// ==== test/tb_corr_top.sv ====
// Correlator top level testbench
`timescale 1ns/1ps

module tb_corr_top;
	import corr_pkg::*;

	localparam int BAUD_DIV = 8;
	localparam int TEST_ARG = 63;
	localparam int W = (TEST_ARG + 1) * WINDOW_UNIT;
	localparam int PKT_CYCLES = PKT_BYTES * 10 * BAUD_DIV;
	localparam int CMD_CYCLES = 12 * BAUD_DIV;
	// Idle check, three single windows, two back to back windows, quiet time after stop
	localparam int TIMEOUT_CYCLES = 500 + 3 * (W + PKT_CYCLES) + (2 * W + PKT_CYCLES)
		+ 2 * W + 16 * CMD_CYCLES + 5000;

	logic intclk;
	logic reset;
	lines_t line_in;
	logic rx;
	logic tx;
	logic integrating;

	byte_t rx_q [$];
	integer seed;
	logic rand_en;
	lines_t model_mask;
	int model_arg;

	// Reference model state
	lines_t m_sample;
	lines_t m_prev;
	int m_active;
	int m_w;
	int pair;
	byte_t m_frame;
	count_t m_counts [NUM_INPUTS];
	count_t m_autos [NUM_INPUTS];
	count_t m_cross [NUM_BASELINES];
	count_t exp_counts [256][NUM_INPUTS];
	count_t exp_autos [256][NUM_INPUTS];
	count_t exp_cross [256][NUM_BASELINES];
	bit exp_valid [256];

	corr_top #(.BAUD_DIV(BAUD_DIV)) corr_top_inst (
		.intclk(intclk), .reset(reset), .line_in(line_in), .rx(rx), .tx(tx),
		.integrating(integrating)
	);

	initial begin
		intclk = 1'b0;
		forever #5 intclk = ~intclk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			abort_run($sformatf("** Error at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp)
			abort_run($sformatf("** Error at %0t ns: %s is %0d, expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("** Error at %0t ns: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	// 8N1 frame, LSB first, then two idle bit times
	task automatic send_byte(input byte_t data);
		@(posedge intclk);
		#1 rx = 1'b0;
		for (int i = 0; i < 8; i++) begin
			repeat (BAUD_DIV) @(posedge intclk);
			#1 rx = data[i];
		end
		repeat (BAUD_DIV) @(posedge intclk);
		#1 rx = 1'b1;
		repeat (3 * BAUD_DIV) @(posedge intclk);
	endtask

	task automatic set_lines(input lines_t value);
		@(posedge intclk);
		#1;
		rand_en = 1'b0;
		line_in = value;
	endtask

	task automatic set_window(input int arg);
		send_byte({OP_WINDOW, 6'(arg)});
		model_arg = arg;
	endtask

	task automatic set_invert(input lines_t mask);
		send_byte({OP_INVERT, 2'b00, mask});
		model_mask = mask;
	endtask

	task automatic wait_integrating(input logic level);
		int waited;
		waited = 0;
		while (integrating !== level && waited < 4 * CMD_CYCLES) begin
			@(negedge intclk);
			waited++;
		end
		if (integrating !== level)
			abort_run($sformatf("integrating did not go to %b after a run command", level));
	endtask

	task automatic run(input logic on);
		send_byte({OP_RUN, 5'd0, on});
		wait_integrating(on);
	endtask

	task automatic get_packet(output corr_result_t r);
		logic [$bits(corr_result_t)-1:0] bits;
		int waited;
		waited = 0;
		bits = '0;
		while (rx_q.size() < PKT_BYTES && waited < 2 * W + PKT_CYCLES) begin
			@(posedge intclk);
			waited++;
		end
		if (rx_q.size() < PKT_BYTES) begin
			abort_run("No complete packet arrived on tx in time");
		end else begin
			check_byte("sync byte", rx_q.pop_front(), SYNC_BYTE);
			for (int i = 1; i < PKT_BYTES; i++)
				bits = {bits[$bits(bits)-9:0], rx_q.pop_front()};
			r = corr_result_t'(bits);
		end
	endtask

	// Lines held constant over a whole window of w edges
	task automatic check_static_window(input corr_result_t r, input lines_t inv, input int w);
		int b;
		b = 0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			check_count($sformatf("counts[%0d]", i), r.counts[i], inv[i] ? count_t'(w) : '0);
			check_count($sformatf("autos[%0d]", i), r.autos[i], inv[i] ? count_t'(w) : '0);
		end
		for (int a = 0; a < NUM_INPUTS; a++)
			for (int c = a + 1; c < NUM_INPUTS; c++) begin
				check_count($sformatf("cross[%0d]", b), r.cross_sums[b],
					(inv[a] && inv[c]) ? count_t'(w) : '0);
				b++;
			end
	endtask

	// Packet must carry the window the model finished last
	task automatic check_model_window(input corr_result_t r);
		check_byte("frame_id", r.frame_id, m_frame - 8'd1);
		if (!exp_valid[r.frame_id]) begin
			abort_run($sformatf("Packet with frame id %0d has no finished window in the model",
				r.frame_id));
		end else begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				check_count($sformatf("counts[%0d]", i), r.counts[i], exp_counts[r.frame_id][i]);
				check_count($sformatf("autos[%0d]", i), r.autos[i], exp_autos[r.frame_id][i]);
			end
			for (int b = 0; b < NUM_BASELINES; b++)
				check_count($sformatf("cross[%0d]", b), r.cross_sums[b],
					exp_cross[r.frame_id][b]);
		end
	endtask

	// tx monitor, samples each bit in its middle
	initial begin
		byte_t b;
		forever begin
			@(negedge intclk);
			if (tx === 1'b0) begin
				repeat (BAUD_DIV / 2) @(negedge intclk);
				for (int i = 0; i < 8; i++) begin
					repeat (BAUD_DIV) @(negedge intclk);
					b[i] = tx;
				end
				repeat (BAUD_DIV) @(negedge intclk);
				if (tx !== 1'b1)
					abort_run("A byte on tx had a low stop bit");
				else
					rx_q.push_back(b);
			end
		end
	end

	// Random line driver
	initial begin
		forever begin
			@(posedge intclk);
			#1;
			if (rand_en)
				line_in = lines_t'($random(seed));
		end
	end

	always @(posedge intclk) begin
		if (reset) begin
			m_active = 0;
			m_frame = '0;
			m_sample = '0;
			m_prev = '0;
		end else if (integrating) begin
			if (m_active == 0) begin
				m_w = (model_arg + 1) * WINDOW_UNIT;
				for (int i = 0; i < NUM_INPUTS; i++) begin
					m_counts[i] = '0;
					m_autos[i] = '0;
				end
				for (int b = 0; b < NUM_BASELINES; b++)
					m_cross[b] = '0;
			end
			for (int i = 0; i < NUM_INPUTS; i++) begin
				m_counts[i] += count_t'(m_sample[i]);
				m_autos[i] += count_t'(m_sample[i] & m_prev[i]);
			end
			pair = 0;
			for (int a = 0; a < NUM_INPUTS; a++)
				for (int c = a + 1; c < NUM_INPUTS; c++) begin
					m_cross[pair] += count_t'(m_sample[a] & m_sample[c]);
					pair++;
				end
			m_active++;
			if (m_active == m_w) begin
				exp_counts[m_frame] = m_counts;
				exp_autos[m_frame] = m_autos;
				exp_cross[m_frame] = m_cross;
				exp_valid[m_frame] = 1'b1;
				m_frame++;
				m_active = 0;
			end
		end else begin
			// Partial window is dropped on stop
			m_active = 0;
		end
		m_prev = m_sample;
		m_sample = line_in ^ model_mask;
	end

	task automatic test_idle();
		repeat (500) begin
			@(negedge intclk);
			check_bit("tx while idle", tx, 1'b1);
			check_bit("integrating while idle", integrating, 1'b0);
		end
		if (rx_q.size() != 0)
			abort_run("A byte arrived on tx with no command sent");
	endtask

	task automatic test_all_ones();
		corr_result_t r;
		set_lines(4'hF);
		set_window(TEST_ARG);
		run(1'b1);
		get_packet(r);
		check_byte("frame_id", r.frame_id, 8'd0);
		check_static_window(r, 4'hF, W);
		run(1'b0);
	endtask

	task automatic test_random();
		corr_result_t r;
		rand_en = 1'b1;
		run(1'b1);
		get_packet(r);
		check_model_window(r);
		run(1'b0);
	endtask

	task automatic test_invert();
		corr_result_t r;
		// Inverted sample is 0011, lines 0 and 1 high
		set_lines(4'b0110);
		set_invert(4'b0101);
		run(1'b1);
		get_packet(r);
		check_static_window(r, 4'b0110 ^ 4'b0101, W);
		run(1'b0);
	endtask

	task automatic test_frames_and_stop();
		corr_result_t first;
		corr_result_t second;
		rand_en = 1'b1;
		run(1'b1);
		// Sent early so that a wrong mask, length or stop shows in both packets
		send_byte({OP_NONE, 6'h2A});
		@(negedge intclk);
		check_bit("integrating after no-op command", integrating, 1'b1);
		get_packet(first);
		check_model_window(first);
		get_packet(second);
		check_byte("frame_id step", second.frame_id - first.frame_id, 8'd1);
		check_model_window(second);
		run(1'b0);
		repeat (2 * W) begin
			@(negedge intclk);
			check_bit("integrating after stop", integrating, 1'b0);
		end
		if (rx_q.size() != 0)
			abort_run("A packet arrived after the stop command");
	endtask

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge intclk);
		abort_run("The run timed out before all tests finished");
	end

	initial begin
		seed = 35;
		rand_en = 1'b0;
		model_mask = '0;
		model_arg = 0;
		reset = 1'b1;
		rx = 1'b1;
		line_in = '0;
		repeat (4) @(posedge intclk);
		#1 reset = 1'b0;
		test_idle();
		test_all_ones();
		test_random();
		test_invert();
		test_frames_and_stop();
		$display("Test OK");
		$finish;
	end

endmodule
